//--- bench/energy_monitor_sva.sv
// concurrent assertions for the energy monitor
// spin to weight handover, result held during a stall, clean sleep entry

`timescale 1ns/1ps

module energy_monitor_sva (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 en_i,
    input logic                 debug_en_i,
    input logic                 spin_valid_i,
    input logic                 energy_ready_i,
    input logic                 config_ready_i, // DUT config_ready_o
    input logic                 spin_ready_i,   // DUT spin_ready_o
    input logic                 weight_ready_i, // DUT weight_ready_o
    input logic                 energy_valid_i, // DUT energy_valid_o
    input energy_pkg::energy_t  energy_i,       // DUT energy_o
    input energy_pkg::row_cnt_t row_idx_i,      // row counter index
    input logic                 cmpt_done_i     // field stage done flag
);
    // after a spin handshake only the weight channel is ready
    ready_handover: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        spin_valid_i && spin_ready_i |=> !config_ready_i && !spin_ready_i &&
            (weight_ready_i || !en_i || debug_en_i))
        else $error("spin handshake did not hand over to the weight channel");

    // result must not move while the sink stalls
    result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_i && !energy_ready_i |=> $stable(energy_i))
        else $error("energy_o changed before its handshake");

    // sleep entry drops the outputs and clears row index and done flag
    quiet_after_disable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(en_i) |=> !config_ready_i && !spin_ready_i && !weight_ready_i &&
            !energy_valid_i && row_idx_i == '0 && !cmpt_done_i)
        else $error("outputs or row state not cleared one cycle after en_i fell");

endmodule

//--- bench/energy_monitor_tb.sv
// testbench of the energy monitor
// clock and reset, xorshift stimulus, reference energy model,
// compare tasks, watchdog and verdict

`timescale 1ns/1ps

`include "energy_cfg.svh"

module energy_monitor_tb;
    localparam int CLK_PERIOD = 100;
    localparam int QUARTER    = CLK_PERIOD / 4;  // sample point after the falling edge
    localparam int NSPIN      = `ENERGY_NUM_SPINS;
    localparam int WW         = `ENERGY_WEIGHT_W;
    localparam int NUM_FRAMES = 23;
    localparam int MAX_CYCLES = NUM_FRAMES * (NSPIN * 40 + 200) + 20; // 16 rows worst case

    logic clk_i, rst_n_i, en_i, debug_en_i;
    logic config_valid_i, config_ready_o, spin_valid_i, spin_ready_o;
    logic weight_valid_i, weight_ready_o, energy_valid_o, energy_ready_i;
    energy_pkg::row_cnt_t    config_rows_i;
    energy_pkg::spin_vec_t   spin_i;
    energy_pkg::weight_row_t weight_i;
    energy_pkg::energy_t     energy_o;

    energy_pkg::weight_row_t wrows [NSPIN];  // weight rows of the frame
    logic [31:0]             rng_state;
    int                      stored_rows;    // row limit held by the DUT
    int                      checks;
    int                      errors;

    energy_monitor dut0 (.*);

    bind energy_monitor energy_monitor_sva sva0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (en_i),
        .debug_en_i     (debug_en_i),
        .spin_valid_i   (spin_valid_i),
        .energy_ready_i (energy_ready_i),
        .config_ready_i (config_ready_o),
        .spin_ready_i   (spin_ready_o),
        .weight_ready_i (weight_ready_o),
        .energy_valid_i (energy_valid_o),
        .energy_i       (energy_o),
        .row_idx_i      (row_idx),
        .cmpt_done_i    (cmpt_done)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped handshaking", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic energy_pkg::weight_row_t random_row();
        energy_pkg::weight_row_t row;
        logic [31:0]             r;
        for (int i = 0; i < NSPIN; i++) begin
            r = next_random();
            row[i*WW +: WW] = (r[WW-1:0] == 8'h80) ? 8'h81 : r[WW-1:0]; // no -128 so field fits
        end
        return row;
    endfunction

    // sum over rows j of s_j times sum over columns i of W_ji times s_i where bit 0 is -1
    function automatic int model_energy(input energy_pkg::spin_vec_t s, input int rows);
        int total;
        int field;
        total = 0;
        for (int j = 0; j < rows; j++) begin
            field = 0;
            for (int i = 0; i < NSPIN; i++) begin
                field += (s[i] ? 1 : -1) * int'($signed(wrows[j][i*WW +: WW]));
            end
            total += (s[j] ? 1 : -1) * field;
        end
        return total;
    endfunction

    task automatic check_energy(input string name, input energy_pkg::energy_t got,
                                input energy_pkg::energy_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_quiet();
        check_flag("config_ready_o", config_ready_o, 1'b0);
        check_flag("spin_ready_o", spin_ready_o, 1'b0);
        check_flag("weight_ready_o", weight_ready_o, 1'b0);
        check_flag("energy_valid_o", energy_valid_o, 1'b0);
    endtask

    // raised valid waits for its ready and returns at the falling edge after the transfer
    task automatic wait_transfer();
        #(QUARTER);
        while (!((config_valid_i && config_ready_o) || (spin_valid_i && spin_ready_o) ||
                 (weight_valid_i && weight_ready_o))) begin
            @(negedge clk_i);
            #(QUARTER);
        end
        @(negedge clk_i);
    endtask

    task automatic freeze(input int cycles);
        debug_en_i = 1'b1;
        repeat (cycles) begin
            @(negedge clk_i);
            check_quiet();       // nothing may transfer while frozen
        end
        debug_en_i = 1'b0;
    endtask

    task automatic drop_enable();
        en_i = 1'b0;
        repeat (3) begin
            @(negedge clk_i);
            check_quiet();
        end
        en_i = 1'b1;
    endtask

    task automatic run_frame(input int rows, input bit do_config, input int gap_max,
                             input int hold_max, input bit ready_early,
                             input int freeze_row, input int abort_row);
        energy_pkg::spin_vec_t spins;
        energy_pkg::energy_t   exp_e;
        energy_pkg::energy_t   first_e;
        logic                  vld_after;
        spins = energy_pkg::spin_vec_t'(next_random());
        foreach (wrows[j]) wrows[j] = random_row();
        energy_ready_i = ready_early;  // sink ready before the result
        if (do_config) begin
            config_valid_i = 1'b1;
            config_rows_i  = energy_pkg::row_cnt_t'(rows);
            wait_transfer();
            config_valid_i = 1'b0;
            stored_rows    = rows;
        end
        spin_valid_i = 1'b1;
        spin_i       = spins;
        wait_transfer();
        spin_valid_i = 1'b0;
        exp_e = energy_pkg::energy_t'(model_energy(spins, stored_rows));
        for (int j = 0; j < stored_rows; j++) begin
            if (j == abort_row) begin
                drop_enable();
                return;
            end
            if (j == freeze_row) begin
                @(negedge clk_i);    // FSM waits in LOAD for the row
                check_flag("weight_ready_o", weight_ready_o, 1'b1);
                freeze(2 + int'(next_random() % 4));
            end
            repeat (int'(next_random() % (gap_max + 1))) @(negedge clk_i); // valid gap
            weight_valid_i = 1'b1;
            weight_i       = wrows[j];
            wait_transfer();
            vld_after      = energy_valid_o;  // one cycle after the weight transfer
            weight_valid_i = 1'b0;
            check_flag("energy_valid_o", vld_after, j == stored_rows - 1);
        end
        first_e = energy_o;
        check_energy("energy_o", first_e, exp_e);
        repeat (int'(next_random() % (hold_max + 1))) begin
            @(negedge clk_i);    // sink stalls
            check_flag("energy_valid_o", energy_valid_o, 1'b1);
            check_energy("energy_o", energy_o, first_e);
        end
        energy_ready_i = 1'b1;
        @(negedge clk_i);
        check_flag("energy_valid_o", energy_valid_o, 1'b0);
        check_flag("spin_ready_o", spin_ready_o, 1'b1);  // back in IDLE
        energy_ready_i = 1'b0;
    endtask

    initial begin : main_seq
        int rows;
        int cut;
        rng_state      = 32'd31;
        checks         = 0;
        errors         = 0;
        stored_rows    = 1;      // reset row limit
        rst_n_i        = 1'b0;
        en_i           = 1'b0;
        debug_en_i     = 1'b0;
        config_valid_i = 1'b0;
        config_rows_i  = '0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        weight_valid_i = 1'b0;
        weight_i       = '0;
        energy_ready_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_quiet();       // still asleep
        end
        en_i = 1'b1;
        // sink always ready with a full and a single row frame first
        run_frame(16, 1'b1, 0, 0, 1'b1, -1, -1);
        run_frame(1, 1'b1, 0, 0, 1'b1, -1, -1);
        repeat (4) begin
            rows = 1 + int'(next_random() % 16);
            run_frame(rows, 1'b1, 0, 0, 1'b1, -1, -1);
        end
        repeat (6) begin
            rows = 1 + int'(next_random() % 16);
            run_frame(rows, 1'b1, 3, 5, 1'b0, -1, -1);
        end
        repeat (3) begin
            rows = 1 + int'(next_random() % 16);
            cut  = int'(next_random() % rows);
            run_frame(rows, 1'b1, 1, 2, 1'b0, cut, -1);
        end
        // enable dropped mid frame and a fresh frame after it
        repeat (2) begin
            rows = 2 + int'(next_random() % 15);
            cut  = 1 + int'(next_random() % (rows - 1));
            run_frame(rows, 1'b1, 1, 0, 1'b0, -1, cut);
            rows = 1 + int'(next_random() % 16);
            run_frame(rows, 1'b1, 1, 2, 1'b0, -1, -1);
        end
        repeat (4) run_frame(0, 1'b0, 1, 2, 1'b0, -1, -1); // stored row limit
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- include/energy_cfg.svh
// sizing macros for the energy monitor
// spin count, weight, field, energy and row count widths

`ifndef ENERGY_CFG_SVH
`define ENERGY_CFG_SVH

// spins per vector, also columns per weight row
`define ENERGY_NUM_SPINS 16

// signed coupling weight
`define ENERGY_WEIGHT_W 8

// one row's local field, weight width plus log2 of the spin count
`define ENERGY_FIELD_W 12

// total energy, field width plus log2 of the row count plus sign margin
`define ENERGY_SUM_W 17

// row count 1..16
`define ENERGY_CNT_W 5

`endif

//--- ising_energy.f
+incdir+include
source/energy_pkg.sv
source/logic_ctrl.sv
source/row_counter.sv
source/field_adder.sv
source/energy_acc.sv
source/energy_monitor.sv
bench/energy_monitor_sva.sv
bench/energy_monitor_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the energy monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module energy_monitor_tb \
    -f ising_energy.f -Mdir obj_dir -o sim_energy

./obj_dir/sim_energy > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

//--- source/energy_acc.sv
// energy accumulator of the energy monitor
// signed row contribution, running sum, energy output

`timescale 1ns/1ps

`include "energy_cfg.svh"

module energy_acc (
    input  logic                  clk_i,     // system clock
    input  logic                  rst_n_i,   // sync reset, active low
    input  energy_pkg::field_t    field_i,   // local field of the current row
    input  energy_pkg::spin_vec_t spins_i,   // stored spins
    input  energy_pkg::row_cnt_t  row_idx_i, // current row
    input  logic                  step_i,    // add the contribution
    input  logic                  clear_i,   // frame end or sleep
    output energy_pkg::energy_t   energy_o   // sum incl. current row
);
    localparam int IDX_W = $clog2(`ENERGY_NUM_SPINS);

    energy_pkg::energy_t acc_q;    // rows already added
    energy_pkg::energy_t field_x;  // field widened
    energy_pkg::energy_t contrib;  // s_j times field
    logic                row_spin; // spin of row j

    assign row_spin = spins_i[row_idx_i[IDX_W-1:0]];
    assign field_x  = energy_pkg::energy_t'(field_i); // sign extend
    assign contrib  = row_spin ? field_x : -field_x;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (step_i) begin
            acc_q <= acc_q + contrib;
        end
    end

    // last row joins without waiting for a step
    assign energy_o = acc_q + contrib;

endmodule

//--- source/energy_monitor.sv
// top level of the Ising energy monitor
// joins the controller FSM, the row counter, the field stage and
// the accumulator behind valid/ready channels

`timescale 1ns/1ps

module energy_monitor (
    input  logic                    clk_i,          // system clock
    input  logic                    rst_n_i,        // sync reset, active low
    input  logic                    en_i,           // block enable
    input  logic                    debug_en_i,     // freeze the FSM

    input  logic                    config_valid_i,
    input  energy_pkg::row_cnt_t    config_rows_i,  // rows per frame, 1..16
    output logic                    config_ready_o,

    input  logic                    spin_valid_i,
    input  energy_pkg::spin_vec_t   spin_i,         // one bit per spin
    output logic                    spin_ready_o,

    input  logic                    weight_valid_i,
    input  energy_pkg::weight_row_t weight_i,       // one row per transfer
    output logic                    weight_ready_o,

    output logic                    energy_valid_o,
    output energy_pkg::energy_t     energy_o,       // raw quadratic term
    input  logic                    energy_ready_i
);
    logic                  cfg_load;     // config handshake
    logic                  spin_load;
    logic                  weight_fire;
    logic                  row_step;
    logic                  frame_done;
    logic                  sleep_clear;
    logic                  clear;        // frame end or sleep entry
    logic                  last_row;
    logic                  cmpt_done;
    energy_pkg::row_cnt_t  row_idx;
    energy_pkg::spin_vec_t spins;
    energy_pkg::field_t    field;

    assign cfg_load = config_valid_i && config_ready_o;
    assign clear    = sleep_clear || frame_done;

    logic_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .en_i            (en_i),
        .debug_en_i      (debug_en_i),
        .config_valid_i  (config_valid_i),
        .config_ready_o  (config_ready_o),
        .spin_valid_i    (spin_valid_i),
        .spin_ready_o    (spin_ready_o),
        .weight_valid_i  (weight_valid_i),
        .weight_ready_o  (weight_ready_o),
        .energy_valid_o  (energy_valid_o),
        .energy_ready_i  (energy_ready_i),
        .counter_ready_i (last_row),
        .cmpt_done_i     (cmpt_done),
        .spin_load_o     (spin_load),
        .weight_fire_o   (weight_fire),
        .row_step_o      (row_step),
        .frame_done_o    (frame_done),
        .clear_o         (sleep_clear)
    );

    row_counter u_rows (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cfg_load_i (cfg_load),
        .cfg_rows_i (config_rows_i),
        .step_i     (row_step),
        .clear_i    (clear),
        .row_idx_o  (row_idx),
        .last_row_o (last_row)
    );

    field_adder u_field (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .spin_load_i   (spin_load),
        .spin_i        (spin_i),
        .weight_fire_i (weight_fire),
        .weight_i      (weight_i),
        .clear_i       (clear),
        .spins_o       (spins),
        .field_o       (field),
        .done_o        (cmpt_done)
    );

    energy_acc u_acc (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .field_i   (field),
        .spins_i   (spins),
        .row_idx_i (row_idx),
        .step_i    (row_step),
        .clear_i   (clear),
        .energy_o  (energy_o)
    );

endmodule

//--- source/energy_pkg.sv
// shared vector and number types of the energy monitor
// spin vector, packed weight row, local field, energy, row count

`include "energy_cfg.svh"

package energy_pkg;

    // one bit per spin, 1 is +1 and 0 is -1
    typedef logic [`ENERGY_NUM_SPINS-1:0] spin_vec_t;

    // all weights of one row, column 0 in the low byte
    typedef logic [`ENERGY_NUM_SPINS*`ENERGY_WEIGHT_W-1:0] weight_row_t;

    // signed sum of one weight row against the spins
    typedef logic signed [`ENERGY_FIELD_W-1:0] field_t;

    // signed quadratic energy term
    typedef logic signed [`ENERGY_SUM_W-1:0] energy_t;

    // row limit or current row index
    typedef logic [`ENERGY_CNT_W-1:0] row_cnt_t;

endpackage

//--- source/field_adder.sv
// local field stage of the energy monitor
// spin vector register, signed sum of one weight row against the spins,
// done flag toward the FSM

`timescale 1ns/1ps

`include "energy_cfg.svh"

module field_adder (
    input  logic                    clk_i,         // system clock
    input  logic                    rst_n_i,       // sync reset, active low
    input  logic                    spin_load_i,   // spin handshake
    input  energy_pkg::spin_vec_t   spin_i,        // incoming spins
    input  logic                    weight_fire_i, // weight handshake
    input  energy_pkg::weight_row_t weight_i,      // incoming weight row
    input  logic                    clear_i,       // frame end or sleep
    output energy_pkg::spin_vec_t   spins_o,       // stored spins
    output energy_pkg::field_t      field_o,       // registered local field
    output logic                    done_o         // field holds a valid row
);
    localparam int NUM_SPINS = `ENERGY_NUM_SPINS;
    localparam int WEIGHT_W  = `ENERGY_WEIGHT_W;

    energy_pkg::spin_vec_t spins_q;  // spin payload
    energy_pkg::field_t    field_q;
    logic                  done_q;

    logic signed [WEIGHT_W-1:0] weight_col;  // one column weight
    energy_pkg::field_t         term;        // sign extended weight
    energy_pkg::field_t         field_sum;   // combinational field

    // sum of +w or -w per column, sign taken from the spin bit
    always_comb begin
        field_sum = '0;
        weight_col = '0;
        term = '0;
        for (int i = 0; i < NUM_SPINS; i++) begin
            weight_col = weight_i[i*WEIGHT_W +: WEIGHT_W];
            term       = energy_pkg::field_t'(weight_col); // sign extend
            if (spins_q[i]) begin
                field_sum = field_sum + term;
            end else begin
                field_sum = field_sum - term;  // spin -1
            end
        end
    end

    // payload, loaded only on the spin handshake
    always_ff @(posedge clk_i) begin
        if (spin_load_i) begin
            spins_q <= spin_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            field_q <= '0;
            done_q  <= 1'b0;
        end else if (clear_i) begin
            field_q <= '0;
            done_q  <= 1'b0;
        end else if (spin_load_i) begin
            done_q  <= 1'b0;      // new frame, no row yet
        end else if (weight_fire_i) begin
            field_q <= field_sum;
            done_q  <= 1'b1;      // stays up across rows
        end
    end

    assign spins_o = spins_q;
    assign field_o = field_q;
    assign done_o  = done_q;

endmodule

//--- source/logic_ctrl.sv
// controller FSM of the energy monitor
// sleep, idle, load and compute states, handshake readies and valid,
// strobes for the counter and the data path

`timescale 1ns/1ps

module logic_ctrl (
    input  logic clk_i,           // system clock
    input  logic rst_n_i,         // sync reset, active low
    input  logic en_i,            // block enable
    input  logic debug_en_i,      // freeze the FSM

    input  logic config_valid_i,  // row count offered
    output logic config_ready_o,  // row count accepted
    input  logic spin_valid_i,    // spin vector offered
    output logic spin_ready_o,    // spin vector accepted
    input  logic weight_valid_i,  // weight row offered
    output logic weight_ready_o,  // weight row accepted
    output logic energy_valid_o,  // energy result offered
    input  logic energy_ready_i,  // energy result taken

    input  logic counter_ready_i, // current row is the last
    input  logic cmpt_done_i,     // local field registered

    output logic spin_load_o,     // spin handshake
    output logic weight_fire_o,   // weight handshake
    output logic row_step_o,      // next row, add contribution
    output logic frame_done_o,    // energy handshake, frame over
    output logic clear_o          // entry to sleep
);
    typedef enum logic [1:0] {
        SLEEP   = 2'b00,
        IDLE    = 2'b01,
        LOAD    = 2'b10,
        COMPUTE = 2'b11
    } state_t;

    state_t state_q, state_d;
    logic   active;  // enabled and not frozen

    assign active = en_i && !debug_en_i;

    assign config_ready_o = (state_q == IDLE) && active;
    assign spin_ready_o   = (state_q == IDLE) && active; // same window as config
    assign weight_ready_o = (state_q == LOAD) && active;
    assign energy_valid_o = (state_q == COMPUTE) && active && cmpt_done_i && counter_ready_i;

    assign spin_load_o   = spin_valid_i && spin_ready_o;
    assign weight_fire_o = weight_valid_i && weight_ready_o;
    assign row_step_o    = (state_q == COMPUTE) && active && cmpt_done_i && !counter_ready_i;
    assign frame_done_o  = energy_valid_o && energy_ready_i;
    assign clear_o       = (state_q != SLEEP) && !en_i; // leaving for sleep

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SLEEP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q; // hold by default, also while frozen
        if (!en_i) begin
            state_d = SLEEP;
        end else if (state_q == SLEEP) begin
            state_d = IDLE;
        end else if (!debug_en_i) begin
            case (state_q)
                IDLE: begin
                    if (spin_load_o) begin
                        state_d = LOAD;
                    end
                end
                LOAD: begin
                    if (weight_fire_o) begin
                        state_d = COMPUTE;
                    end
                end
                COMPUTE: begin
                    case ({energy_ready_i, counter_ready_i, cmpt_done_i})
                        3'b001, 3'b101: state_d = LOAD;    // more rows follow
                        3'b111:         state_d = IDLE;    // result taken
                        3'b011:         state_d = COMPUTE; // result held for the sink
                        default:        state_d = COMPUTE; // field not ready yet
                    endcase
                end
                default: begin
                    state_d = SLEEP;
                end
            endcase
        end
    end

endmodule

//--- source/row_counter.sv
// row counter of the energy monitor
// stored row limit, current row index, last row flag

`timescale 1ns/1ps

`include "energy_cfg.svh"

module row_counter (
    input  logic                 clk_i,      // system clock
    input  logic                 rst_n_i,    // sync reset, active low
    input  logic                 cfg_load_i, // config handshake
    input  energy_pkg::row_cnt_t cfg_rows_i, // requested row count
    input  logic                 step_i,     // advance one row
    input  logic                 clear_i,    // back to row 0
    output energy_pkg::row_cnt_t row_idx_o,  // row being processed
    output logic                 last_row_o  // index is the final row
);
    localparam energy_pkg::row_cnt_t MAX_ROWS = energy_pkg::row_cnt_t'(`ENERGY_NUM_SPINS);
    localparam energy_pkg::row_cnt_t ONE_ROW  = energy_pkg::row_cnt_t'(1);

    energy_pkg::row_cnt_t rows_q;    // row limit
    energy_pkg::row_cnt_t idx_q;     // current row
    energy_pkg::row_cnt_t rows_lim;  // clamped request

    // keep the limit inside 1..16
    always_comb begin
        rows_lim = cfg_rows_i;
        if (cfg_rows_i == '0) begin
            rows_lim = ONE_ROW;
        end else if (cfg_rows_i > MAX_ROWS) begin
            rows_lim = MAX_ROWS;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rows_q <= ONE_ROW; // single row until configured
            idx_q  <= '0;
        end else begin
            if (cfg_load_i) begin
                rows_q <= rows_lim;
            end
            if (clear_i) begin
                idx_q <= '0;   // clear wins over step
            end else if (step_i) begin
                idx_q <= idx_q + ONE_ROW;
            end
        end
    end

    assign row_idx_o  = idx_q;
    assign last_row_o = (idx_q == rows_q - ONE_ROW);

endmodule
